// ==== hw/alu_cfg_pkg.sv ====
package alu_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath size defaults
  ////////////////////////////////////////////////////////////

  // Data width of the core, also the width of every operand
  localparam int XLEN_DEF = 32;

  // Shared buffer registers owned by the address unit
  localparam int NUM_SBF_DEF = 2;

endpackage

// ==== hw/alu_op_pkg.sv ====
package alu_op_pkg;

  ////////////////////////////////////////////////////////////
  // Opcodes seen by the shared datapath
  ////////////////////////////////////////////////////////////

  // LUI and SWAP both arrive here as OP_MVOP2
  typedef enum logic [4:0] {
    OP_NONE, OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_MVOP2,
    OP_MAX, OP_MIN, OP_MAXU, OP_MINU,
    OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT, OP_CMP_GT, OP_CMP_LTU, OP_CMP_GTU
  } alu_op_e;

  // Requestors of the datapath, in grant priority order
  typedef enum logic [1:0] {
    REQ_NONE, REQ_ALU, REQ_BJP, REQ_AGU
  } alu_req_e;

  // Which requestor may issue which opcode
  function automatic logic op_allowed(alu_req_e req, alu_op_e op);
    logic ok;
    case (req)
      REQ_ALU: ok = op inside {OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SLL,
                               OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_MVOP2};
      REQ_BJP: ok = op inside {OP_ADD, OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT,
                               OP_CMP_GT, OP_CMP_LTU, OP_CMP_GTU};
      REQ_AGU: ok = op inside {OP_ADD, OP_AND, OP_OR, OP_XOR, OP_MAX, OP_MIN,
                               OP_MAXU, OP_MINU, OP_MVOP2};
      // No request, nothing goes through
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

endpackage

// ==== hw/alu_req_mux.sv ====
`timescale 1ns/10ps

module alu_req_mux #(
  parameter int XLEN = 32
) (
  input  logic                 alu_req,
  input  logic                 bjp_req,
  input  logic                 agu_req,
  input  alu_op_pkg::alu_op_e  alu_op,
  input  alu_op_pkg::alu_op_e  bjp_op,
  input  alu_op_pkg::alu_op_e  agu_op,
  input  logic [XLEN-1:0]      alu_op1,
  input  logic [XLEN-1:0]      alu_op2,
  input  logic [XLEN-1:0]      bjp_op1,
  input  logic [XLEN-1:0]      bjp_op2,
  input  logic [XLEN-1:0]      agu_op1,
  input  logic [XLEN-1:0]      agu_op2,
  output alu_op_pkg::alu_op_e  sel_op,
  output logic [XLEN-1:0]      sel_op1,
  output logic [XLEN-1:0]      sel_op2
);

  import alu_op_pkg::*;

  alu_req_e        grant;
  alu_op_e         req_op;
  logic [XLEN-1:0] req_op1;
  logic [XLEN-1:0] req_op2;
  logic            op_ok;

  ////////////////////////////////////////////////////////////
  // Fixed priority grant
  ////////////////////////////////////////////////////////////

  // Requests should be one-hot, ALU wins if they are not
  always_comb begin
    if (alu_req) begin
      grant = REQ_ALU;
    end else if (bjp_req) begin
      grant = REQ_BJP;
    end else if (agu_req) begin
      grant = REQ_AGU;
    end else begin
      grant = REQ_NONE;
    end
  end

  // Pick opcode and operands of the granted requestor
  always_comb begin
    case (grant)
      REQ_ALU: begin
        req_op  = alu_op;
        req_op1 = alu_op1;
        req_op2 = alu_op2;
      end
      REQ_BJP: begin
        req_op  = bjp_op;
        req_op1 = bjp_op1;
        req_op2 = bjp_op2;
      end
      REQ_AGU: begin
        req_op  = agu_op;
        req_op1 = agu_op1;
        req_op2 = agu_op2;
      end
      default: begin
        req_op  = OP_NONE;
        req_op1 = '0;
        req_op2 = '0;
      end
    endcase
  end

  // Illegal opcode for this requestor turns into a no-op
  assign op_ok   = op_allowed(grant, req_op);
  assign sel_op  = op_ok ? req_op : OP_NONE;
  assign sel_op1 = op_ok ? req_op1 : '0;
  assign sel_op2 = op_ok ? req_op2 : '0;

endmodule

// ==== hw/alu_shifter.sv ====
`timescale 1ns/10ps

module alu_shifter #(
  parameter int XLEN = 32
) (
  input  alu_op_pkg::alu_op_e  sel_op,
  input  logic [XLEN-1:0]      sel_op1,
  input  logic [XLEN-1:0]      sel_op2,
  output logic [XLEN-1:0]      sll_res,
  output logic [XLEN-1:0]      srl_res,
  output logic [XLEN-1:0]      sra_res
);

  import alu_op_pkg::*;

  // Shift amount width
  localparam int SHW = $clog2(XLEN);

  logic            op_shift;
  logic            op_right;
  logic [XLEN-1:0] shifter_in1;
  logic [SHW-1:0]  shifter_in2;
  logic [XLEN-1:0] shifter_res;
  logic [XLEN-1:0] eff_mask;

  // Mirror a word end to end
  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

  assign op_shift = sel_op inside {OP_SLL, OP_SRL, OP_SRA};
  assign op_right = sel_op inside {OP_SRL, OP_SRA};

  ////////////////////////////////////////////////////////////
  // One left shifter for all three shifts
  ////////////////////////////////////////////////////////////

  // Gated off when no shift, right shifts go in mirrored
  assign shifter_in1 = {XLEN{op_shift}} & (op_right ? bit_rev(sel_op1) : sel_op1);
  assign shifter_in2 = {SHW{op_shift}} & sel_op2[SHW-1:0];
  assign shifter_res = shifter_in1 << shifter_in2;

  assign sll_res = shifter_res;
  // Mirror back to get the logical right shift
  assign srl_res = bit_rev(shifter_res);

  // Fill the vacated high bits with the sign
  assign eff_mask = {XLEN{1'b1}} >> shifter_in2;
  assign sra_res  = (srl_res & eff_mask) | ({XLEN{sel_op1[XLEN-1]}} & ~eff_mask);

endmodule

// ==== hw/alu_arith.sv ====
`timescale 1ns/10ps

module alu_arith #(
  parameter int XLEN = 32
) (
  input  alu_op_pkg::alu_op_e  sel_op,
  input  logic [XLEN-1:0]      sel_op1,
  input  logic [XLEN-1:0]      sel_op2,
  output logic [XLEN-1:0]      add_res,
  output logic [XLEN-1:0]      xor_res,
  output logic                 lt_flag,
  output logic                 bjp_cmp_res
);

  import alu_op_pkg::*;

  logic            op_unsigned;
  logic            adder_add;
  logic            adder_sub;
  logic            adder_on;
  logic [XLEN:0]   adder_op1;
  logic [XLEN:0]   adder_op2;
  logic [XLEN:0]   adder_in1;
  logic [XLEN:0]   adder_in2;
  logic [XLEN:0]   adder_res;
  logic            xorer_on;
  logic            neq;

  ////////////////////////////////////////////////////////////
  // Shared adder, one bit wider than the data
  ////////////////////////////////////////////////////////////

  // Unsigned compares take a zero top bit
  assign op_unsigned = sel_op inside {OP_SLTU, OP_CMP_LTU, OP_CMP_GTU, OP_MAXU, OP_MINU};
  assign adder_op1 = {~op_unsigned & sel_op1[XLEN-1], sel_op1};
  assign adder_op2 = {~op_unsigned & sel_op2[XLEN-1], sel_op2};

  // Every ordering check is a subtraction
  assign adder_add = (sel_op == OP_ADD);
  assign adder_sub = sel_op inside {OP_SUB, OP_SLT, OP_SLTU, OP_MAX, OP_MIN, OP_MAXU,
                                    OP_MINU, OP_CMP_LT, OP_CMP_GT, OP_CMP_LTU, OP_CMP_GTU};
  assign adder_on  = adder_add | adder_sub;

  // Gate inputs off when idle, sub is op1 + ~op2 + 1
  assign adder_in1 = {(XLEN+1){adder_on}} & adder_op1;
  assign adder_in2 = {(XLEN+1){adder_on}} & (adder_sub ? ~adder_op2 : adder_op2);
  assign adder_res = adder_in1 + adder_in2 + {{XLEN{1'b0}}, adder_sub};

  assign add_res = adder_res[XLEN-1:0];
  // Negative extended difference means op1 below op2
  assign lt_flag = adder_res[XLEN];

  ////////////////////////////////////////////////////////////
  // Shared XOR unit
  ////////////////////////////////////////////////////////////

  assign xorer_on = sel_op inside {OP_XOR, OP_CMP_EQ, OP_CMP_NE};
  assign xor_res  = ({XLEN{xorer_on}} & sel_op1) ^ ({XLEN{xorer_on}} & sel_op2);

  // Any differing bit means not equal
  assign neq = |xor_res;

  // Branch compares, gt is the not-less-than test used by BGE/BGEU
  assign bjp_cmp_res = ((sel_op == OP_CMP_EQ)  & ~neq)
                     | ((sel_op == OP_CMP_NE)  &  neq)
                     | ((sel_op == OP_CMP_LT)  &  lt_flag)
                     | ((sel_op == OP_CMP_LTU) &  lt_flag)
                     | ((sel_op == OP_CMP_GT)  & ~lt_flag)
                     | ((sel_op == OP_CMP_GTU) & ~lt_flag);

endmodule

// ==== hw/alu_result_sel.sv ====
`timescale 1ns/10ps

module alu_result_sel #(
  parameter int XLEN = 32
) (
  input  alu_op_pkg::alu_op_e  sel_op,
  input  logic [XLEN-1:0]      sel_op1,
  input  logic [XLEN-1:0]      sel_op2,
  input  logic [XLEN-1:0]      add_res,
  input  logic [XLEN-1:0]      xor_res,
  input  logic                 lt_flag,
  input  logic [XLEN-1:0]      sll_res,
  input  logic [XLEN-1:0]      srl_res,
  input  logic [XLEN-1:0]      sra_res,
  output logic [XLEN-1:0]      alu_res
);

  import alu_op_pkg::*;

  logic [XLEN-1:0] or_res;
  logic [XLEN-1:0] and_res;
  logic [XLEN-1:0] slt_res;
  logic            maxmin_sel_op1;
  logic [XLEN-1:0] maxmin_res;

  // OR and AND are cheap, no gating
  assign or_res  = sel_op1 | sel_op2;
  assign and_res = sel_op1 & sel_op2;

  // SLT/SLTU reuse the adder sign
  assign slt_res = {{(XLEN-1){1'b0}}, lt_flag};

  // Max keeps op1 when not less, min keeps op1 when less
  assign maxmin_sel_op1 = ((sel_op inside {OP_MAX, OP_MAXU}) & ~lt_flag)
                        | ((sel_op inside {OP_MIN, OP_MINU}) &  lt_flag);
  assign maxmin_res = maxmin_sel_op1 ? sel_op1 : sel_op2;

  ////////////////////////////////////////////////////////////
  // Final result
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (sel_op)
      OP_ADD, OP_SUB: alu_res = add_res;
      OP_XOR:         alu_res = xor_res;
      OP_OR:          alu_res = or_res;
      OP_AND:         alu_res = and_res;
      OP_SLL:         alu_res = sll_res;
      OP_SRL:         alu_res = srl_res;
      OP_SRA:         alu_res = sra_res;
      OP_SLT, OP_SLTU: alu_res = slt_res;
      // LUI immediate or swap data sits in op2
      OP_MVOP2:       alu_res = sel_op2;
      OP_MAX, OP_MIN, OP_MAXU, OP_MINU: alu_res = maxmin_res;
      // Compares and no-op give zero
      default:        alu_res = '0;
    endcase
  end

endmodule

// ==== hw/alu_shared_buf.sv ====
`timescale 1ns/10ps

module alu_shared_buf #(
  parameter int XLEN    = 32,
  parameter int NUM_SBF = 2
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [NUM_SBF-1:0]             sbf_ena,
  input  logic [XLEN-1:0]                sbf_nxt,
  output logic [NUM_SBF-1:0][XLEN-1:0]   sbf_r
);

  ////////////////////////////////////////////////////////////
  // Shared buffer bank
  ////////////////////////////////////////////////////////////

  // One next value, each enable bit picks its word
  always_ff @(posedge clk) begin
    if (reset) begin
      sbf_r <= '0;
    end else begin
      for (int i = 0; i < NUM_SBF; i++) begin
        if (sbf_ena[i]) begin
          sbf_r[i] <= sbf_nxt;
        end
      end
    end
  end

endmodule

// ==== hw/alu_dpath.sv ====
`timescale 1ns/10ps

module alu_dpath #(
  parameter int XLEN    = alu_cfg_pkg::XLEN_DEF,
  parameter int NUM_SBF = alu_cfg_pkg::NUM_SBF_DEF
) (
  input  logic                          clk,
  input  logic                          reset,
  // Regular ALU
  input  logic                          alu_req,
  input  alu_op_pkg::alu_op_e           alu_op,
  input  logic [XLEN-1:0]               alu_op1,
  input  logic [XLEN-1:0]               alu_op2,
  // Branch unit
  input  logic                          bjp_req,
  input  alu_op_pkg::alu_op_e           bjp_op,
  input  logic [XLEN-1:0]               bjp_op1,
  input  logic [XLEN-1:0]               bjp_op2,
  // Address unit
  input  logic                          agu_req,
  input  alu_op_pkg::alu_op_e           agu_op,
  input  logic [XLEN-1:0]               agu_op1,
  input  logic [XLEN-1:0]               agu_op2,
  input  logic [NUM_SBF-1:0]            sbf_ena,
  input  logic [XLEN-1:0]               sbf_nxt,
  // Results
  output logic [XLEN-1:0]               alu_res,
  output logic                          bjp_cmp_res,
  output logic [NUM_SBF-1:0][XLEN-1:0]  sbf_r
);

  import alu_op_pkg::*;

  alu_op_e         sel_op;
  logic [XLEN-1:0] sel_op1;
  logic [XLEN-1:0] sel_op2;
  logic [XLEN-1:0] add_res;
  logic [XLEN-1:0] xor_res;
  logic            lt_flag;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;

  // Requestor mux
  alu_req_mux #(.XLEN(XLEN)) u_req_mux (
    .alu_req (alu_req), .bjp_req (bjp_req), .agu_req (agu_req),
    .alu_op  (alu_op),  .bjp_op  (bjp_op),  .agu_op  (agu_op),
    .alu_op1 (alu_op1), .alu_op2 (alu_op2),
    .bjp_op1 (bjp_op1), .bjp_op2 (bjp_op2),
    .agu_op1 (agu_op1), .agu_op2 (agu_op2),
    .sel_op  (sel_op),  .sel_op1 (sel_op1), .sel_op2 (sel_op2)
  );

  alu_shifter #(.XLEN(XLEN)) u_shifter (
    .sel_op  (sel_op),  .sel_op1 (sel_op1), .sel_op2 (sel_op2),
    .sll_res (sll_res), .srl_res (srl_res), .sra_res (sra_res)
  );

  // Adder, XOR and branch compare
  alu_arith #(.XLEN(XLEN)) u_arith (
    .sel_op  (sel_op),  .sel_op1 (sel_op1), .sel_op2 (sel_op2),
    .add_res (add_res), .xor_res (xor_res), .lt_flag (lt_flag),
    .bjp_cmp_res (bjp_cmp_res)
  );

  alu_result_sel #(.XLEN(XLEN)) u_result_sel (
    .sel_op  (sel_op),  .sel_op1 (sel_op1), .sel_op2 (sel_op2),
    .add_res (add_res), .xor_res (xor_res), .lt_flag (lt_flag),
    .sll_res (sll_res), .srl_res (srl_res), .sra_res (sra_res),
    .alu_res (alu_res)
  );

  // Address unit buffers
  alu_shared_buf #(.XLEN(XLEN), .NUM_SBF(NUM_SBF)) u_shared_buf (
    .clk     (clk),     .reset   (reset),
    .sbf_ena (sbf_ena), .sbf_nxt (sbf_nxt), .sbf_r (sbf_r)
  );

endmodule

// ==== tests/alu_checker.sv ====
`timescale 1ns/10ps

module alu_checker #(
  parameter int XLEN    = 32,
  parameter int NUM_SBF = 2
) (
  input logic                         clk,
  input logic                         reset,
  input logic                         check_en,
  input logic                         alu_req, bjp_req, agu_req,
  input alu_op_pkg::alu_op_e          alu_op, bjp_op, agu_op,
  input logic [XLEN-1:0]              alu_op1, alu_op2, bjp_op1, bjp_op2,
  input logic [XLEN-1:0]              agu_op1, agu_op2,
  input logic [NUM_SBF-1:0]           sbf_ena,
  input logic [XLEN-1:0]              sbf_nxt,
  input logic [XLEN-1:0]              alu_res,
  input logic                         bjp_cmp_res,
  input logic [NUM_SBF-1:0][XLEN-1:0] sbf_r
);

  import alu_op_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic                         grant_ok;
  alu_op_e                      g_op;
  logic [XLEN-1:0]              g_a;
  logic [XLEN-1:0]              g_b;
  logic [XLEN-1:0]              exp_res;
  logic                         exp_cmp;
  logic [NUM_SBF-1:0][XLEN-1:0] sbf_model;
  string                        cur_test = "";
  int                           test_errs = 0;
  int                           checks = 0;
  int                           error_total = 0;
  int                           tests_passed = 0;
  int                           tests_failed = 0;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] calc_res(input alu_op_e op,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    r = '0;
    case (op)
      OP_ADD:   r = a + b;
      OP_SUB:   r = a - b;
      OP_XOR:   r = a ^ b;
      OP_OR:    r = a | b;
      OP_AND:   r = a & b;
      OP_SLL:   r = a << b[SHW-1:0];
      OP_SRL:   r = a >> b[SHW-1:0];
      OP_SRA:   r = $signed(a) >>> b[SHW-1:0];
      OP_SLT:   r[0] = $signed(a) < $signed(b);
      OP_SLTU:  r[0] = a < b;
      OP_MVOP2: r = b;
      OP_MAX:   r = ($signed(a) > $signed(b)) ? a : b;
      OP_MIN:   r = ($signed(a) < $signed(b)) ? a : b;
      OP_MAXU:  r = (a > b) ? a : b;
      OP_MINU:  r = (a < b) ? a : b;
      default:  r = '0;
    endcase
    return r;
  endfunction

  // GT and GTU mean not less than, as BGE and BGEU use them
  function automatic logic calc_cmp(input alu_op_e op,
                                    input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b);
    case (op)
      OP_CMP_EQ:  return a == b;
      OP_CMP_NE:  return a != b;
      OP_CMP_LT:  return $signed(a) < $signed(b);
      OP_CMP_GT:  return $signed(a) >= $signed(b);
      OP_CMP_LTU: return a < b;
      OP_CMP_GTU: return a >= b;
      default:    return 1'b0;
    endcase
  endfunction

  // Highest priority request wins, a bad opcode gives zero
  always_comb begin
    grant_ok = 1'b0;
    g_op     = OP_NONE;
    g_a      = '0;
    g_b      = '0;
    if (alu_req) begin
      grant_ok = op_allowed(REQ_ALU, alu_op);
      g_op     = alu_op;
      g_a      = alu_op1;
      g_b      = alu_op2;
    end else if (bjp_req) begin
      grant_ok = op_allowed(REQ_BJP, bjp_op);
      g_op     = bjp_op;
      g_a      = bjp_op1;
      g_b      = bjp_op2;
    end else if (agu_req) begin
      grant_ok = op_allowed(REQ_AGU, agu_op);
      g_op     = agu_op;
      g_a      = agu_op1;
      g_b      = agu_op2;
    end
    exp_res = grant_ok ? calc_res(g_op, g_a, g_b) : '0;
    exp_cmp = grant_ok ? calc_cmp(g_op, g_a, g_b) : 1'b0;
  end

  // Buffer model, written on the enabled edge
  always @(posedge clk) begin
    if (reset) begin
      sbf_model <= '0;
    end else begin
      for (int i = 0; i < NUM_SBF; i++) begin
        if (sbf_ena[i]) begin
          sbf_model[i] <= sbf_nxt;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Comparison and reporting
  ////////////////////////////////////////////////////////////

  task automatic compare(input string what, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] act);
    checks++;
    if (exp !== act) begin
      test_errs++;
      error_total++;
      $display("Fail %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // Mid-cycle, well after the inputs settle
  always @(negedge clk) begin
    if (check_en) begin
      compare("alu_res", exp_res, alu_res);
      compare("bjp_cmp_res", XLEN'(exp_cmp), XLEN'(bjp_cmp_res));
      for (int i = 0; i < NUM_SBF; i++) begin
        compare($sformatf("sbf_r[%0d]", i), sbf_model[i], sbf_r[i]);
      end
    end
  end

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("Test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s: %0d mismatches", cur_test, test_errs);
    end
  endtask

  task automatic report_totals();
    $display("Tests passed %0d, tests failed %0d, checks %0d, mismatches %0d",
             tests_passed, tests_failed, checks, error_total);
  endtask

endmodule

// ==== tests/tb_alu_dpath.sv ====
`timescale 1ns/10ps

module tb_alu_dpath;

  import alu_cfg_pkg::*;
  import alu_op_pkg::*;

  localparam int XLEN         = XLEN_DEF;
  localparam int NUM_SBF      = NUM_SBF_DEF;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int N_TXN        = 200;
  localparam int NUM_TESTS    = 6;
  // Twice the transaction time of all tests plus reset
  localparam int WD_TIME = 2 * NUM_TESTS * N_TXN * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  logic                         clk;
  logic                         reset;
  logic                         check_en;
  logic                         alu_req, bjp_req, agu_req;
  alu_op_e                      alu_op, bjp_op, agu_op;
  logic [XLEN-1:0]              alu_op1, alu_op2, bjp_op1, bjp_op2, agu_op1, agu_op2;
  logic [NUM_SBF-1:0]           sbf_ena;
  logic [XLEN-1:0]              sbf_nxt;
  logic [XLEN-1:0]              alu_res;
  logic                         bjp_cmp_res;
  logic [NUM_SBF-1:0][XLEN-1:0] sbf_r;

  // Opcodes each requestor may issue
  alu_op_e alu_ops [11] = '{OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SLL,
                            OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_MVOP2};
  alu_op_e bjp_ops [7]  = '{OP_ADD, OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT,
                            OP_CMP_GT, OP_CMP_LTU, OP_CMP_GTU};
  alu_op_e agu_ops [9]  = '{OP_ADD, OP_AND, OP_OR, OP_XOR, OP_MAX, OP_MIN,
                            OP_MAXU, OP_MINU, OP_MVOP2};

  alu_dpath #(.XLEN(XLEN), .NUM_SBF(NUM_SBF)) UUT (.*);

  alu_checker #(.XLEN(XLEN), .NUM_SBF(NUM_SBF)) chk (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random stimulus helpers
  ////////////////////////////////////////////////////////////

  // Operands leaning on corner values
  function automatic logic [XLEN-1:0] edge_value();
    logic [XLEN-1:0] v;
    case ($urandom % 8)
      0: v = '0;
      1: v = '1;
      2: v = {1'b1, {(XLEN-1){1'b0}}};
      3: v = {1'b0, {(XLEN-1){1'b1}}};
      4: v = XLEN'(1);
      default: v = XLEN'($urandom);
    endcase
    return v;
  endfunction

  // Every fourth pair is equal
  function automatic logic [XLEN-1:0] pair_value(input logic [XLEN-1:0] a);
    return ($urandom % 4 == 0) ? a : edge_value();
  endfunction

  function automatic alu_op_e any_op();
    return alu_op_e'(5'($urandom % 22));
  endfunction

  function automatic alu_op_e allowed_op(input int who);
    alu_op_e op;
    case (who)
      1: op = alu_ops[$urandom % 11];
      2: op = bjp_ops[$urandom % 7];
      default: op = agu_ops[$urandom % 9];
    endcase
    return op;
  endfunction

  task automatic drive_idle();
    {alu_req, bjp_req, agu_req} = 3'b000;
    alu_op = OP_NONE;
    bjp_op = OP_NONE;
    agu_op = OP_NONE;
    {alu_op1, alu_op2, bjp_op1, bjp_op2, agu_op1, agu_op2} = '0;
    sbf_ena = '0;
    sbf_nxt = '0;
  endtask

  // Raise one request (1 ALU, 2 branch, 3 address)
  task automatic issue(input int who, input alu_op_e op);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = edge_value();
    b = pair_value(a);
    // Shift by zero and by the full amount
    if (op inside {OP_SLL, OP_SRL, OP_SRA} && $urandom % 2 == 1) begin
      b = ($urandom % 2 == 1) ? XLEN'(XLEN - 1) : '0;
    end
    case (who)
      1: begin
        alu_req = 1'b1;
        alu_op  = op;
        alu_op1 = a;
        alu_op2 = b;
      end
      2: begin
        bjp_req = 1'b1;
        bjp_op  = op;
        bjp_op1 = a;
        bjp_op2 = b;
      end
      default: begin
        agu_req = 1'b1;
        agu_op  = op;
        agu_op1 = a;
        agu_op2 = b;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Named tests
  ////////////////////////////////////////////////////////////

  task automatic run_test(input string name, input int mode);
    int      who;
    alu_op_e op;
    chk.begin_test(name);
    for (int n = 0; n < N_TXN; n++) begin
      @(posedge clk);
      #2;
      drive_idle();
      case (mode)
        0, 1, 2: issue(mode + 1, allowed_op(mode + 1));
        3: begin
          // No request, or an opcode the requestor may not issue
          who = int'($urandom % 4);
          op  = any_op();
          while (who != 0 && op_allowed(alu_req_e'(2'(who)), op)) begin
            op = any_op();
          end
          if (who != 0) begin
            issue(who, op);
          end else begin
            alu_op  = op;
            agu_op  = op;
            alu_op1 = edge_value();
            agu_op2 = edge_value();
          end
        end
        4: begin
          // One requestor stays quiet and 0 lets all three fire
          who = int'($urandom % 4);
          for (int r = 1; r <= 3; r++) begin
            if (r != who) begin
              issue(r, allowed_op(r));
            end
          end
        end
        default: begin
          sbf_ena = NUM_SBF'($urandom);
          sbf_nxt = edge_value();
          issue(3, allowed_op(3));
        end
      endcase
    end
    // One idle cycle so the last buffer write shows on sbf_r
    @(posedge clk);
    #2;
    drive_idle();
    @(posedge clk);
    chk.end_test();
  endtask

  initial begin
    void'($urandom(32'h9dd511fa));
    clk      = 1'b0;
    reset    = 1'b1;
    check_en = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset    = 1'b0;
    check_en = 1'b1;
    run_test("alu_ops", 0);
    run_test("branch_cmp", 1);
    run_test("agu_ops", 2);
    run_test("disallowed", 3);
    run_test("priority", 4);
    run_test("shared_buf", 5);
    chk.report_totals();
    if (chk.tests_failed == 0 && chk.error_total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WD_TIME);
    $display("Timeout: the tests did not finish within %0d ns", WD_TIME);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== all.f ====
hw/alu_cfg_pkg.sv
hw/alu_op_pkg.sv
hw/alu_req_mux.sv
hw/alu_shifter.sv
hw/alu_arith.sv
hw/alu_result_sel.sv
hw/alu_shared_buf.sv
hw/alu_dpath.sv
tests/alu_checker.sv
tests/tb_alu_dpath.sv

// ==== Makefile ====
TOP := tb_alu_dpath

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f all.f --Mdir obj_dir -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
